// File: hdl/rwPkg.sv
package rwPkg;

        // ************************************************
        // Sizes
        // ************************************************

        localparam int dataWidth = 32;
        localparam int numGlobals = 8;
        localparam int numWindows = 4;
        localparam int bankSize = 8;

        // Bits that pick a register inside one bank
        localparam int bankBits = $clog2(bankSize);

        // Logical register numbers seen by the program
        localparam int logAddrBits = 5;
        localparam int numLogical = 2 ** logAddrBits;

        // ************************************************
        // Physical layout
        // ************************************************

        // Globals first, then all out banks, then all local banks
        localparam int outBase = numGlobals;
        localparam int localBase = outBase + numWindows * bankSize;
        localparam int numPhys = localBase + numWindows * bankSize;

        localparam int physAddrBits = $clog2(numPhys);
        localparam int winBits = $clog2(numWindows);

        // Upper two bits of a logical number select its region
        localparam logic [1:0] regionGlobal = 2'd0;
        localparam logic [1:0] regionOut = 2'd1;
        localparam logic [1:0] regionLocal = 2'd2;
        localparam logic [1:0] regionIn = 2'd3;

        // ************************************************
        // Types
        // ************************************************

        typedef logic [dataWidth-1:0] data_t;

        typedef logic [logAddrBits-1:0] logAddr_t;

        typedef logic [physAddrBits-1:0] physAddr_t;

        typedef logic [winBits-1:0] window_t;

        // One bit per physical register
        typedef logic [numPhys-1:0] clrMask_t;

endpackage

// File: hdl/regFileIf.sv
`timescale 1ns/100ps

interface regFileIf;

        import rwPkg::*;

        // Physical read addresses and the data coming back
        physAddr_t rdAddrA;
        physAddr_t rdAddrB;
        data_t     rdDataA;
        data_t     rdDataB;

        // Single write port
        physAddr_t wrAddr;
        logic      wrEn;
        data_t     wrData;

        // Registers to zero on the next edge
        clrMask_t  clrMask;

        // Address side, owned by the window logic
        modport translator
        (
                output rdAddrA,
                output rdAddrB,
                output wrAddr,
                output wrEn,
                output wrData,
                output clrMask,
                input  rdDataA,
                input  rdDataB
        );

        // Register array side
        modport storage
        (
                input  rdAddrA,
                input  rdAddrB,
                input  wrAddr,
                input  wrEn,
                input  wrData,
                input  clrMask,
                output rdDataA,
                output rdDataB
        );

endinterface

// File: hdl/windowTranslator.sv
`timescale 1ns/100ps

module windowTranslator
(
        input  rwPkg::logAddr_t sa,
        input  rwPkg::logAddr_t sb,
        input  rwPkg::logAddr_t loadSelect,
        input  rwPkg::window_t  cwp,
        input  logic            loadEnable,
        input  logic            clearEnable,
        input  rwPkg::data_t    portC,
        output rwPkg::data_t    portA,
        output rwPkg::data_t    portB,
        regFileIf.translator    rf
);

        import rwPkg::*;

        clrMask_t clrMask;

        // ************************************************
        // Logical to physical mapping
        // ************************************************

        // Ins of window w live in the out bank of window w+1
        function automatic physAddr_t mapAddr(input logAddr_t logAddr, input window_t win);
                window_t   nextWin;
                physAddr_t offset;
                physAddr_t outBank;
                physAddr_t localBank;
                physAddr_t inBank;
                physAddr_t result;

                nextWin = window_t'(win + 1'b1);
                offset = physAddr_t'(logAddr[bankBits-1:0]);

                outBank = physAddr_t'(outBase) + physAddr_t'(win) * physAddr_t'(bankSize);
                localBank = physAddr_t'(localBase) + physAddr_t'(win) * physAddr_t'(bankSize);
                inBank = physAddr_t'(outBase) + physAddr_t'(nextWin) * physAddr_t'(bankSize);

                case (logAddr[logAddrBits-1:bankBits])
                        regionGlobal:
                                result = physAddr_t'(logAddr);
                        regionOut:
                                result = outBank + offset;
                        regionLocal:
                                result = localBank + offset;
                        regionIn:
                                result = inBank + offset;
                        default:
                                result = '0;
                endcase

                return result;
        endfunction

        // ************************************************
        // Read ports
        // ************************************************

        assign rf.rdAddrA = mapAddr(sa, cwp);
        assign rf.rdAddrB = mapAddr(sb, cwp);

        // %g0 is hardwired to zero
        assign portA = (sa == '0) ? '0 : rf.rdDataA;
        assign portB = (sb == '0) ? '0 : rf.rdDataB;

        // ************************************************
        // Write port
        // ************************************************

        assign rf.wrAddr = mapAddr(loadSelect, cwp);
        assign rf.wrData = portC;

        // Drop writes aimed at logical 0
        assign rf.wrEn = loadEnable && (loadSelect != '0);

        // ************************************************
        // Clear mask
        // ************************************************

        // Every register visible from the current window,
        // i.e. globals, outs, locals and ins
        always_comb
        begin
                clrMask = '0;
                if (clearEnable)
                begin
                        for (int i = 0; i < numLogical; i++)
                        begin
                                clrMask[mapAddr(logAddr_t'(i), cwp)] = 1'b1;
                        end
                end
        end

        assign rf.clrMask = clrMask;

        // Mapped addresses must land inside the physical array
        always_comb
        begin
                assert final (rf.rdAddrA < numPhys && rf.rdAddrB < numPhys
                        && rf.wrAddr < numPhys)
                else
                        $error("windowTranslator: physical address out of range");
        end

endmodule

// File: hdl/physRegFile.sv
`timescale 1ns/100ps

module physRegFile
(
        input logic       Clk,
        input logic       rstN,
        regFileIf.storage rf
);

        import rwPkg::*;

        // ************************************************
        // Storage
        // ************************************************

        // Entry 0 is never written and stays zero after reset
        data_t regs [numPhys];

        // One-hot write select and next value per register
        logic [numPhys-1:0] wrSel;
        data_t              regsNext [numPhys];

        // ************************************************
        // Write decode
        // ************************************************

        always_comb
        begin
                wrSel = '0;
                if (rf.wrEn)
                begin
                        wrSel[rf.wrAddr] = 1'b1;
                end
        end

        // Clear beats a write to the same register
        always_comb
        begin
                for (int i = 0; i < numPhys; i++)
                begin
                        if (rf.clrMask[i])
                        begin
                                regsNext[i] = '0;
                        end
                        else if (wrSel[i])
                        begin
                                regsNext[i] = rf.wrData;
                        end
                        else
                        begin
                                regsNext[i] = regs[i];
                        end
                end
        end

        // ************************************************
        // Register update
        // ************************************************

        always_ff @(posedge Clk)
        begin
                if (!rstN)
                begin
                        for (int i = 0; i < numPhys; i++)
                        begin
                                regs[i] <= '0;
                        end
                end
                else
                begin
                        for (int i = 0; i < numPhys; i++)
                        begin
                                regs[i] <= regsNext[i];
                        end
                end
        end

        // ************************************************
        // Read ports
        // ************************************************

        // Combinational reads with no bypass of a pending write
        assign rf.rdDataA = regs[rf.rdAddrA];
        assign rf.rdDataB = regs[rf.rdAddrB];

        // ************************************************
        // Checks
        // ************************************************

        // Logical 0 writes are filtered upstream
        noWriteToZero: assert property (
                @(posedge Clk) disable iff (!rstN)
                rf.wrEn |-> rf.wrAddr != '0)
        else
                $error("physRegFile: write to physical register 0");

endmodule

// File: hdl/registerWindows.sv
`timescale 1ns/100ps

module registerWindows
(
        input  logic            Clk,
        input  logic            rstN,

        // Read side
        input  rwPkg::logAddr_t sa,
        input  rwPkg::logAddr_t sb,
        output rwPkg::data_t    portA,
        output rwPkg::data_t    portB,

        // Write side
        input  rwPkg::logAddr_t loadSelect,
        input  rwPkg::data_t    portC,
        input  logic            loadEnable,

        // Window control
        input  rwPkg::window_t  cwp,
        input  logic            clearEnable
);

        // ************************************************
        // Physical access bus
        // ************************************************

        regFileIf rfBus ();

        // ************************************************
        // Window translation
        // ************************************************

        // Logical numbers and cwp in, physical accesses out
        windowTranslator translator
        (
                .sa          (sa),
                .sb          (sb),
                .loadSelect  (loadSelect),
                .cwp         (cwp),
                .loadEnable  (loadEnable),
                .clearEnable (clearEnable),
                .portC       (portC),
                .portA       (portA),
                .portB       (portB),
                .rf          (rfBus.translator)
        );

        // ************************************************
        // Physical registers
        // ************************************************

        // 72 entries, globals plus four windows of outs and locals
        physRegFile storage
        (
                .Clk  (Clk),
                .rstN (rstN),
                .rf   (rfBus.storage)
        );

endmodule

// File: test/registerWindowsVectors.svh
`ifndef REGISTER_WINDOWS_VECTORS_SVH
`define REGISTER_WINDOWS_VECTORS_SVH

// Columns: name, cwp, operation, random data, loadSelect, portC, sa, sb
// Reads are checked before the edge, so a write row sees the old contents
localparam int numVectors = 37;

localparam vector_t vectors [numVectors] = '{
        // Globals are shared by every window
        '{"glbWrite",   2'd0, opWrite, 1'b0, 5'd1,  32'h1111_0001, 5'd0,  5'd1},
        '{"glbWrite",   2'd1, opWrite, 1'b1, 5'd7,  32'h0000_0000, 5'd1,  5'd7},
        '{"glbRead",    2'd2, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd1,  5'd7},
        '{"glbRead",    2'd3, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd7,  5'd1},
        '{"zeroWrite",  2'd0, opWrite, 1'b0, 5'd0,  32'hDEAD_BEEF, 5'd0,  5'd1},
        '{"zeroRead",   2'd2, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd0,  5'd0},
        // Locals are private to one window
        '{"locWrite",   2'd0, opWrite, 1'b0, 5'd16, 32'hA0A0_0010, 5'd16, 5'd17},
        '{"locWrite",   2'd1, opWrite, 1'b0, 5'd16, 32'hB1B1_0010, 5'd16, 5'd23},
        '{"locWrite",   2'd2, opWrite, 1'b1, 5'd23, 32'h0000_0000, 5'd16, 5'd23},
        '{"locRead",    2'd0, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd16, 5'd23},
        '{"locRead",    2'd1, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd16, 5'd23},
        '{"locRead",    2'd2, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd16, 5'd23},
        '{"locRead",    2'd3, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd16, 5'd23},
        // Outs of one window are the ins of the window below
        '{"outWrite",   2'd0, opWrite, 1'b1, 5'd8,  32'h0000_0000, 5'd8,  5'd24},
        '{"outWrite",   2'd1, opWrite, 1'b0, 5'd13, 32'hC0DE_0113, 5'd13, 5'd29},
        '{"inRead",     2'd3, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd24, 5'd8},
        '{"inRead",     2'd0, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd29, 5'd13},
        '{"inWrite",    2'd2, opWrite, 1'b1, 5'd26, 32'h0000_0000, 5'd26, 5'd10},
        '{"outRead",    2'd3, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd10, 5'd26},
        '{"inWrite",    2'd3, opWrite, 1'b0, 5'd31, 32'h5A5A_0031, 5'd31, 5'd15},
        '{"outRead",    2'd0, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd15, 5'd8},
        // Two different registers in one cycle
        '{"dualRead",   2'd1, opWrite, 1'b1, 5'd20, 32'h0000_0000, 5'd13, 5'd20},
        '{"dualRead",   2'd1, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd20, 5'd13},
        '{"dualRead",   2'd3, opWrite, 1'b1, 5'd9,  32'h0000_0000, 5'd9,  5'd1},
        '{"dualRead",   2'd3, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd9,  5'd24},
        // Clear of window 2
        '{"clrSetup",   2'd2, opWrite, 1'b1, 5'd18, 32'h0000_0000, 5'd18, 5'd7},
        '{"clrSetup",   2'd2, opWrite, 1'b1, 5'd10, 32'h0000_0000, 5'd10, 5'd18},
        '{"clrSetup",   2'd2, opWrite, 1'b1, 5'd27, 32'h0000_0000, 5'd27, 5'd10},
        '{"clear",      2'd2, opClear, 1'b0, 5'd0,  32'h0000_0000, 5'd18, 5'd27},
        '{"clrCheck",   2'd2, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd18, 5'd27},
        '{"clrCheck",   2'd2, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd10, 5'd1},
        '{"clrCheck",   2'd2, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd7,  5'd23},
        '{"clrKeep",    2'd0, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd16, 5'd8},
        '{"clrKeep",    2'd1, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd16, 5'd13},
        '{"clrKeep",    2'd3, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd24, 5'd31},
        '{"postClear",  2'd2, opWrite, 1'b1, 5'd18, 32'h0000_0000, 5'd18, 5'd0},
        '{"postClear",  2'd2, opRead,  1'b0, 5'd0,  32'h0000_0000, 5'd18, 5'd19}
};

`endif

// File: test/registerWindowsTb.sv
`timescale 1ns/100ps

module registerWindowsTb;

        import rwPkg::*;

        // ************************************************
        // Stimulus table format
        // ************************************************

        typedef enum logic [1:0] {opRead, opWrite, opClear} op_t;

        typedef struct packed {
                logic [8*12-1:0] name;
                window_t         win;
                op_t             op;
                logic            rnd;
                logAddr_t        sel;
                data_t           data;
                logAddr_t        sa;
                logAddr_t        sb;
        } vector_t;

        `include "registerWindowsVectors.svh"

        localparam int clkPeriod = 10;
        localparam int cycleLimit = 20 + 4 * numVectors;

        logic     Clk;
        logic     rstN;
        logAddr_t sa;
        logAddr_t sb;
        logAddr_t loadSelect;
        data_t    portC;
        logic     loadEnable;
        window_t  cwp;
        logic     clearEnable;
        data_t    portA;
        data_t    portB;

        // Reference copy of the 72 physical registers
        data_t model [numPhys];
        int    seed = 39;
        int    cycleCount;

        registerWindows DUT
        (
                .Clk         (Clk),
                .rstN        (rstN),
                .sa          (sa),
                .sb          (sb),
                .portA       (portA),
                .portB       (portB),
                .loadSelect  (loadSelect),
                .portC       (portC),
                .loadEnable  (loadEnable),
                .cwp         (cwp),
                .clearEnable (clearEnable)
        );

        initial
        begin
                Clk = 1'b0;
                forever
                begin
                        #(clkPeriod / 2) Clk = ~Clk;
                end
        end

        // Runaway guard
        initial
        begin
                cycleCount = 0;
                while (cycleCount < cycleLimit)
                begin
                        @(posedge Clk);
                        cycleCount++;
                end
                $display("ERROR: run did not finish within %0d clock cycles", cycleLimit);
                $display("sim failed");
                $fatal(1, "timeout");
        end

        // ************************************************
        // Reference model
        // ************************************************

        // Ins of a window sit in the out bank of the next window up
        function automatic int physIndex(input int logReg, input int win);
                int k;
                k = logReg % bankSize;
                if (logReg < numGlobals)
                        return logReg;
                else if (logReg < numGlobals + bankSize)
                        return outBase + win * bankSize + k;
                else if (logReg < numGlobals + 2 * bankSize)
                        return localBase + win * bankSize + k;
                else
                        return outBase + ((win + 1) % numWindows) * bankSize + k;
        endfunction

        function automatic data_t expectedRead(input int logReg, input int win);
                if (logReg == 0)
                        return '0;
                return model[physIndex(logReg, win)];
        endfunction

        // Globals, own outs, own locals and the next window's outs
        task automatic clearModel(input int win);
                for (int k = 0; k < bankSize; k++)
                begin
                        model[k] = '0;
                        model[outBase + win * bankSize + k] = '0;
                        model[localBase + win * bankSize + k] = '0;
                        model[outBase + ((win + 1) % numWindows) * bankSize + k] = '0;
                end
        endtask

        // ************************************************
        // Checking and stimulus
        // ************************************************

        task automatic checkValue(input string testName, input data_t expected,
                                  input data_t actual);
                if (expected !== actual)
                begin
                        $display("CHECK FAILED %s expected %h actual %h",
                                 testName, expected, actual);
                        $display("sim failed");
                        $fatal(1, "stopping at first mismatch");
                end
        endtask

        // Drive on the falling edge, sample just before the rising edge commits
        task automatic applyVector(input vector_t v);
                data_t wrValue;
                data_t expA;
                data_t expB;
                string testName;
                @(negedge Clk);
                testName = $sformatf("%0s", v.name);
                wrValue = v.rnd ? data_t'($random(seed)) : v.data;
                cwp = v.win;
                sa = v.sa;
                sb = v.sb;
                loadSelect = v.sel;
                portC = wrValue;
                loadEnable = (v.op == opWrite);
                clearEnable = (v.op == opClear);
                expA = expectedRead(v.sa, v.win);
                expB = expectedRead(v.sb, v.win);
                @(posedge Clk);
                checkValue({testName, " portA"}, expA, portA);
                checkValue({testName, " portB"}, expB, portB);
                if (v.op == opWrite && v.sel != 0)
                        model[physIndex(v.sel, v.win)] = wrValue;
                else if (v.op == opClear)
                        clearModel(v.win);
        endtask

        initial
        begin
                rstN = 1'b0;
                sa = '0;
                sb = '0;
                loadSelect = '0;
                portC = '0;
                loadEnable = 1'b0;
                cwp = '0;
                clearEnable = 1'b0;
                for (int i = 0; i < numPhys; i++)
                        model[i] = '0;

                repeat (10) @(posedge Clk);
                @(negedge Clk);
                rstN = 1'b1;

                // Every register of every window starts at zero
                for (int w = 0; w < numWindows; w++)
                begin
                        for (int r = 0; r < numLogical; r += 2)
                        begin
                                @(negedge Clk);
                                cwp = window_t'(w);
                                sa = logAddr_t'(r);
                                sb = logAddr_t'(r + 1);
                                @(posedge Clk);
                                checkValue($sformatf("resetRead w%0d r%0d", w, r),
                                           expectedRead(r, w), portA);
                                checkValue($sformatf("resetRead w%0d r%0d", w, r + 1),
                                           expectedRead(r + 1, w), portB);
                        end
                end

                for (int i = 0; i < numVectors; i++)
                        applyVector(vectors[i]);

                @(negedge Clk);
                loadEnable = 1'b0;
                clearEnable = 1'b0;
                $display("sim passed");
                $finish;
        end

endmodule

// File: registerWindows.f
+incdir+test
hdl/rwPkg.sv
hdl/regFileIf.sv
hdl/windowTranslator.sv
hdl/physRegFile.sv
hdl/registerWindows.sv
test/registerWindowsTb.sv

// File: Bender.yml
package:
  name: registerWindows

dependencies: {}

sources:
  # RTL in compile order
  - files:
      - hdl/rwPkg.sv
      - hdl/regFileIf.sv
      - hdl/windowTranslator.sv
      - hdl/physRegFile.sv
      - hdl/registerWindows.sv

  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/registerWindowsTb.sv
